// ==== experiar_soc.f ====
+incdir+source
source/experiar_soc_pkg.sv
source/sram_32x512.sv
source/local_memory.sv
source/wishbone_interconnect.sv
source/experiar_soc.sv
sim/clock_gen.sv
sim/experiar_soc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the experiar_soc testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
	--top-module experiar_soc_tb \
	-Mdir "$BUILD_DIR" \
	-f experiar_soc.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vexperiar_soc_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST PASSED" "$LOG_FILE"; then
	echo "Simulation succeeded"
	exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Synchronous reset, released on a rising edge
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

// ==== sim/experiar_soc_tb.sv ====
`timescale 1ns/1ps
`include "experiar_config.svh"

module experiar_soc_tb;

	localparam int STALL_TIMEOUT = 8;
	localparam int RESP_TIMEOUT  = 8;
	localparam int RESET_TIMEOUT = 20;

	// One bus access and the response the address map predicts for it
	typedef struct packed {
		logic                          we;
		logic [`WB_ADR_W-1:0]          adr;
		experiar_soc_pkg::wb_sel_t     sel;
		experiar_soc_pkg::wb_data_t    dat;
		logic                          exp_err;
		experiar_soc_pkg::wb_data_t    exp_dat;
		experiar_soc_pkg::slave_sel_e  exp_slave;
	} entry_t;

	logic                          wb_clk;
	logic                          reset;
	logic                          cyc;
	logic                          stb;
	logic                          we;
	experiar_soc_pkg::wb_sel_t     sel;
	logic [`WB_ADR_W-1:0]          adr;
	experiar_soc_pkg::wb_data_t    dat_w;
	logic                          wb_ack;
	logic                          wb_err;
	logic                          wb_stall;
	experiar_soc_pkg::wb_data_t    dat_r;
	experiar_soc_pkg::slave_sel_e  la_data;

	entry_t                        table_q[$];
	experiar_soc_pkg::wb_data_t    shadow [logic [`WB_ADR_W-3:0]];
	logic [31:0]                   rand_state = 32'h5841a295;

	clock_gen u_clock_gen (.clk_o (wb_clk), .reset_o (reset));

	experiar_soc DUT (
		.wb_clk_i (wb_clk), .reset_i (reset),
		.wb_cyc_i (cyc), .wb_stb_i (stb), .wb_we_i (we),
		.wb_sel_i (sel), .wb_adr_i (adr), .wb_dat_i (dat_w),
		.wb_ack_o (wb_ack), .wb_err_o (wb_err), .wb_stall_o (wb_stall),
		.wb_dat_o (dat_r), .la_data_o (la_data)
	);

	function automatic logic [31:0] next_random();
		rand_state = rand_state ^ (rand_state << 13);
		rand_state = rand_state ^ (rand_state >> 17);
		rand_state = rand_state ^ (rand_state << 5);
		return rand_state;
	endfunction

	// Address map: regions 0..2 are memories, the rest is unmapped
	function automatic experiar_soc_pkg::slave_sel_e slave_of(input logic [`WB_ADR_W-1:0] a);
		case (a[`SLAVE_IDX_HI:`SLAVE_IDX_LO])
			4'd0:    return experiar_soc_pkg::SLAVE_CORE0_MEM;
			4'd1:    return experiar_soc_pkg::SLAVE_CORE1_MEM;
			4'd2:    return experiar_soc_pkg::SLAVE_VIDEO_MEM;
			default: return experiar_soc_pkg::SLAVE_NONE;
		endcase
	endfunction

	function automatic int banks_of(input int region);
		return (region == 2) ? `VIDEO_MEM_BANKS : `CORE_MEM_BANKS;
	endfunction

	// Each bank holds 2 KB
	function automatic int region_bytes(input experiar_soc_pkg::slave_sel_e s);
		if (s == experiar_soc_pkg::SLAVE_NONE) return 0;
		return banks_of(int'(s)) * 2048;
	endfunction

	function automatic logic [`WB_ADR_W-1:0] word_address(input int region, input int bank,
			input int word);
		return `WB_ADR_W'((region << `SLAVE_IDX_LO) + bank * 2048 + word * 4);
	endfunction

	task automatic abort_run(input string reason);
		$display("Error at %0t: %s", $time, reason);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, want);
			$display("TEST FAILED");
			$fatal(1, "Simulation stopped");
		end
	endtask

	// Append one access and update the shadow memory in issue order
	task automatic add_access(input logic w, input logic [`WB_ADR_W-1:0] a,
			input experiar_soc_pkg::wb_sel_t s, input experiar_soc_pkg::wb_data_t d);
		entry_t                      e;
		logic [`WB_ADR_W-3:0]        key;
		experiar_soc_pkg::wb_data_t  word;
		e.we        = w;
		e.adr       = a;
		e.sel       = s;
		e.dat       = d;
		e.exp_slave = slave_of(a);
		e.exp_err   = (int'(a[`SLAVE_ADR_W-1:0]) >= region_bytes(e.exp_slave));
		e.exp_dat   = '0;
		key = a[`WB_ADR_W-1:2];
		if (!e.exp_err && w) begin
			word = shadow.exists(key) ? shadow[key] : '0;
			for (int b = 0; b < `WB_SEL_W; b++) begin
				if (s[b]) word[b*8 +: 8] = d[b*8 +: 8];
			end
			shadow[key] = word;
		end else if (!e.exp_err) begin
			if (!shadow.exists(key)) abort_run("stimulus table reads a word never written");
			e.exp_dat = shadow[key];
		end
		table_q.push_back(e);
	endtask

	task automatic build_table();
		int words[3];
		words = '{0, 5, 511};
		// Full words into every bank, then read back one memory at a time
		for (int pass = 0; pass < 2; pass++) begin
			for (int r = 0; r < 3; r++) begin
				for (int b = 0; b < banks_of(r); b++) begin
					for (int k = 0; k < 3; k++) begin
						if (pass == 0) add_access(1'b1, word_address(r, b, words[k]), 4'hF,
							next_random());
						else add_access(1'b0, word_address(r, b, words[k]), 4'hF, '0);
					end
				end
			end
		end
		// Back to back reads hopping between regions
		for (int b = 0; b < 2; b++) begin
			for (int k = 0; k < 3; k++) begin
				for (int r = 0; r < 3; r++) add_access(1'b0, word_address(r, b, words[k]), 4'hF, '0);
			end
		end
		// Partial byte selects
		add_access(1'b1, 28'h000_0814, 4'b0101, next_random());
		add_access(1'b0, 28'h000_0814, 4'hF, '0);
		add_access(1'b1, 28'h000_0814, 4'b1000, next_random());
		add_access(1'b0, 28'h000_0814, 4'hF, '0);
		add_access(1'b1, 28'h200_1800, 4'b0010, next_random());
		add_access(1'b0, 28'h200_1800, 4'hF, '0);
		add_access(1'b1, 28'h100_07FC, 4'b0000, next_random());
		add_access(1'b0, 28'h100_07FC, 4'hF, '0);
		// Unmapped regions must not reach any memory
		add_access(1'b1, 28'h300_0000, 4'hF, next_random());
		add_access(1'b0, 28'h300_0000, 4'hF, '0);
		add_access(1'b1, 28'h700_0814, 4'hF, next_random());
		add_access(1'b1, 28'hF00_1800, 4'hF, next_random());
		add_access(1'b0, 28'hF00_1800, 4'hF, '0);
		add_access(1'b0, 28'h000_0000, 4'hF, '0);
		add_access(1'b0, 28'h000_0814, 4'hF, '0);
		add_access(1'b0, 28'h200_1800, 4'hF, '0);
		// Past the end of a mapped region, each write would alias a low word
		add_access(1'b1, 28'h000_1000, 4'hF, next_random());
		add_access(1'b1, 28'h100_1FFC, 4'hF, next_random());
		add_access(1'b1, 28'h200_2000, 4'hF, next_random());
		add_access(1'b1, 28'h2FF_FFFC, 4'hF, next_random());
		add_access(1'b0, 28'h200_2000, 4'hF, '0);
		add_access(1'b0, 28'h000_0000, 4'hF, '0);
		add_access(1'b0, 28'h100_0FFC, 4'hF, '0);
		add_access(1'b0, 28'h200_0000, 4'hF, '0);
		add_access(1'b0, 28'h200_1FFC, 4'hF, '0);
	endtask

	task automatic drive_idle();
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		sel   = '0;
		adr   = '0;
		dat_w = '0;
	endtask

	task automatic drive_request(input entry_t e);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = e.we;
		sel   = e.sel;
		adr   = e.adr;
		dat_w = e.dat;
	endtask

	task automatic check_response(input int n);
		entry_t e;
		e = table_q[n];
		check_value($sformatf("entry %0d err", n), 32'(wb_err), 32'(e.exp_err));
		check_value($sformatf("entry %0d ack", n), 32'(wb_ack), 32'(!e.exp_err));
		if (!e.exp_err && !e.we) check_value($sformatf("entry %0d read data", n), dat_r, e.exp_dat);
	endtask

	// Issue the table pipelined and match responses against the issue order
	task automatic apply_table();
		int                            idx;
		int                            n;
		int                            stall_wait;
		int                            resp_wait;
		int                            stall_seen;
		int                            outstanding[$];
		logic                          pending;
		logic                          accepted;
		logic                          exp_stall;
		entry_t                        cur;
		experiar_soc_pkg::slave_sel_e  last_slave;
		idx        = 0;
		stall_wait = 0;
		resp_wait  = 0;
		stall_seen = 0;
		pending    = 1'b0;
		cur        = '0;
		last_slave = experiar_soc_pkg::SLAVE_NONE;
		while (idx < table_q.size() || outstanding.size() > 0) begin
			if (idx < table_q.size()) begin
				cur = table_q[idx];
				drive_request(cur);
				#1;
				exp_stall = pending && (cur.exp_slave != last_slave);
				check_value($sformatf("entry %0d stall", idx), 32'(wb_stall), 32'(exp_stall));
				accepted = !wb_stall;
				if (wb_stall) stall_seen++;
			end else begin
				drive_idle();
				accepted = 1'b0;
			end
			@(negedge wb_clk);
			if (accepted) begin
				check_value($sformatf("entry %0d probe", idx), 32'(la_data), 32'(cur.exp_slave));
				outstanding.push_back(idx);
				last_slave = cur.exp_slave;
				idx++;
				stall_wait = 0;
			end else if (idx < table_q.size()) begin
				stall_wait++;
				if (stall_wait > STALL_TIMEOUT) abort_run("stall did not drop in time");
			end
			pending = accepted;
			if (wb_ack || wb_err) begin
				if (outstanding.size() == 0) abort_run("response arrived with nothing outstanding");
				n = outstanding.pop_front();
				check_response(n);
				resp_wait = 0;
			end else if (outstanding.size() > 0) begin
				resp_wait++;
				if (resp_wait > RESP_TIMEOUT) abort_run("no response to an accepted request");
			end
		end
		drive_idle();
		check_value("stall seen on region switches", 32'(stall_seen > 0), 32'd1);
	endtask

	initial begin
		int wait_cycles;
		drive_idle();
		build_table();
		wait_cycles = 0;
		@(negedge wb_clk);
		while (reset) begin
			@(negedge wb_clk);
			wait_cycles++;
			if (wait_cycles > RESET_TIMEOUT) abort_run("reset was never released");
		end
		check_value("ack after reset", 32'(wb_ack), 32'd0);
		check_value("err after reset", 32'(wb_err), 32'd0);
		check_value("stall after reset", 32'(wb_stall), 32'd0);
		check_value("probe after reset", 32'(la_data), 32'(experiar_soc_pkg::SLAVE_NONE));
		apply_table();
		@(negedge wb_clk);
		check_value("ack with bus idle", 32'(wb_ack), 32'd0);
		check_value("err with bus idle", 32'(wb_err), 32'd0);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== source/experiar_config.svh ====
`ifndef EXPERIAR_CONFIG_SVH
`define EXPERIAR_CONFIG_SVH

// Host bus widths
`define WB_ADR_W 28
`define WB_DAT_W 32
`define WB_SEL_W 4

// Address as seen by one slave
`define SLAVE_ADR_W 24

// Region bits that pick the slave
`define SLAVE_IDX_HI 27
`define SLAVE_IDX_LO 24

// One bank is 512 words of 32 bits
`define SRAM_ADDRESS_SIZE 9

`define CORE_MEM_BANKS 2
`define VIDEO_MEM_BANKS 4

`endif

// ==== source/experiar_soc.sv ====
`timescale 1ns/1ps
`include "experiar_config.svh"

module experiar_soc (
	input  logic                             wb_clk_i,
	input  logic                             reset_i,
	input  logic                             wb_cyc_i,
	input  logic                             wb_stb_i,
	input  logic                             wb_we_i,
	input  experiar_soc_pkg::wb_sel_t        wb_sel_i,
	input  logic [`WB_ADR_W-1:0]             wb_adr_i,
	input  experiar_soc_pkg::wb_data_t       wb_dat_i,
	output logic                             wb_ack_o,
	output logic                             wb_err_o,
	output logic                             wb_stall_o,
	output experiar_soc_pkg::wb_data_t       wb_dat_o,
	output experiar_soc_pkg::slave_sel_e     la_data_o
);

	// Core 0 memory
	logic                          c0_cyc, c0_stb, c0_we, c0_ack, c0_err;
	experiar_soc_pkg::wb_sel_t     c0_sel;
	experiar_soc_pkg::slave_adr_t  c0_adr;
	experiar_soc_pkg::wb_data_t    c0_wdat, c0_rdat;

	// Core 1 memory
	logic                          c1_cyc, c1_stb, c1_we, c1_ack, c1_err;
	experiar_soc_pkg::wb_sel_t     c1_sel;
	experiar_soc_pkg::slave_adr_t  c1_adr;
	experiar_soc_pkg::wb_data_t    c1_wdat, c1_rdat;

	// Video memory
	logic                          vm_cyc, vm_stb, vm_we, vm_ack, vm_err;
	experiar_soc_pkg::wb_sel_t     vm_sel;
	experiar_soc_pkg::slave_adr_t  vm_adr;
	experiar_soc_pkg::wb_data_t    vm_wdat, vm_rdat;

	wishbone_interconnect u_interconnect (
		.wb_clk_i (wb_clk_i), .reset_i (reset_i),
		.wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
		.wb_sel_i (wb_sel_i), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
		.wb_ack_o (wb_ack_o), .wb_err_o (wb_err_o), .wb_stall_o (wb_stall_o),
		.wb_dat_o (wb_dat_o),
		.s0_ack_i (c0_ack), .s0_err_i (c0_err), .s0_dat_i (c0_rdat),
		.s0_cyc_o (c0_cyc), .s0_stb_o (c0_stb), .s0_we_o (c0_we),
		.s0_sel_o (c0_sel), .s0_adr_o (c0_adr), .s0_dat_o (c0_wdat),
		.s1_ack_i (c1_ack), .s1_err_i (c1_err), .s1_dat_i (c1_rdat),
		.s1_cyc_o (c1_cyc), .s1_stb_o (c1_stb), .s1_we_o (c1_we),
		.s1_sel_o (c1_sel), .s1_adr_o (c1_adr), .s1_dat_o (c1_wdat),
		.s2_ack_i (vm_ack), .s2_err_i (vm_err), .s2_dat_i (vm_rdat),
		.s2_cyc_o (vm_cyc), .s2_stb_o (vm_stb), .s2_we_o (vm_we),
		.s2_sel_o (vm_sel), .s2_adr_o (vm_adr), .s2_dat_o (vm_wdat),
		.probe_current_slave_o (la_data_o)
	);

	local_memory #(.BANKS(`CORE_MEM_BANKS)) core0_memory (
		.wb_clk_i (wb_clk_i), .reset_i (reset_i),
		.wb_cyc_i (c0_cyc), .wb_stb_i (c0_stb), .wb_we_i (c0_we),
		.wb_sel_i (c0_sel), .wb_adr_i (c0_adr), .wb_dat_i (c0_wdat),
		.wb_ack_o (c0_ack), .wb_err_o (c0_err), .wb_dat_o (c0_rdat)
	);

	local_memory #(.BANKS(`CORE_MEM_BANKS)) core1_memory (
		.wb_clk_i (wb_clk_i), .reset_i (reset_i),
		.wb_cyc_i (c1_cyc), .wb_stb_i (c1_stb), .wb_we_i (c1_we),
		.wb_sel_i (c1_sel), .wb_adr_i (c1_adr), .wb_dat_i (c1_wdat),
		.wb_ack_o (c1_ack), .wb_err_o (c1_err), .wb_dat_o (c1_rdat)
	);

	// Frame buffer side, twice the banks
	local_memory #(.BANKS(`VIDEO_MEM_BANKS)) video_memory (
		.wb_clk_i (wb_clk_i), .reset_i (reset_i),
		.wb_cyc_i (vm_cyc), .wb_stb_i (vm_stb), .wb_we_i (vm_we),
		.wb_sel_i (vm_sel), .wb_adr_i (vm_adr), .wb_dat_i (vm_wdat),
		.wb_ack_o (vm_ack), .wb_err_o (vm_err), .wb_dat_o (vm_rdat)
	);

endmodule

// ==== source/experiar_soc_pkg.sv ====
`include "experiar_config.svh"

package experiar_soc_pkg;

	// Slave picked by the region bits of the host address
	typedef enum logic [1:0] {
		SLAVE_CORE0_MEM = 2'd0,
		SLAVE_CORE1_MEM = 2'd1,
		SLAVE_VIDEO_MEM = 2'd2,
		SLAVE_NONE      = 2'd3
	} slave_sel_e;

	// Bus payload
	typedef logic [`WB_DAT_W-1:0] wb_data_t;

	// Byte lanes
	typedef logic [`WB_SEL_W-1:0] wb_sel_t;

	// Slave side address, region bits stripped
	typedef logic [`SLAVE_ADR_W-1:0] slave_adr_t;

endpackage

// ==== source/local_memory.sv ====
`timescale 1ns/1ps
`include "experiar_config.svh"

module local_memory #(
	parameter int BANKS = 2
) (
	input  logic                             wb_clk_i,
	input  logic                             reset_i,
	input  logic                             wb_cyc_i,
	input  logic                             wb_stb_i,
	input  logic                             wb_we_i,
	input  experiar_soc_pkg::wb_sel_t        wb_sel_i,
	input  experiar_soc_pkg::slave_adr_t     wb_adr_i,
	input  experiar_soc_pkg::wb_data_t       wb_dat_i,
	output logic                             wb_ack_o,
	output logic                             wb_err_o,
	output experiar_soc_pkg::wb_data_t       wb_dat_o
);

	localparam int BANK_W  = $clog2(BANKS);
	// Byte offset bits 1..0, word in bank from bit 2
	localparam int WORD_LO = 2;
	localparam int BANK_LO = WORD_LO + `SRAM_ADDRESS_SIZE;
	localparam int TOP_LO  = BANK_LO + BANK_W;

	logic                                  request;
	logic                                  in_range;
	logic [BANK_W-1:0]                     bank_sel;
	logic [`SRAM_ADDRESS_SIZE-1:0]         word_adr;
	logic [BANK_W-1:0]                     bank_q;
	logic                                  ack_q;
	logic                                  err_q;
	experiar_soc_pkg::wb_data_t            bank_dout [BANKS];

	assign request  = wb_cyc_i && wb_stb_i;
	assign word_adr = wb_adr_i[WORD_LO +: `SRAM_ADDRESS_SIZE];
	assign bank_sel = wb_adr_i[BANK_LO +: BANK_W];

	// Anything past BANKS x 2 KB is an error
	assign in_range = (wb_adr_i[`SLAVE_ADR_W-1:TOP_LO] == '0);

	genvar i;
	generate
		for (i = 0; i < BANKS; i++) begin : g_bank
			logic cs;

			assign cs = request && in_range && (bank_sel == BANK_W'(i));

			sram_32x512 u_sram (
				.wb_clk_i (wb_clk_i),
				.cs_i     (cs),
				.we_i     (wb_we_i),
				.wmask_i  (wb_sel_i),
				.addr_i   (word_adr),
				.din_i    (wb_dat_i),
				.dout_o   (bank_dout[i])
			);
		end
	endgenerate

	// Response one cycle after the strobe
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= request && in_range;
			err_q <= request && !in_range;
		end
	end

	// Remember which bank answers next cycle
	always_ff @(posedge wb_clk_i) begin
		if (request) begin
			bank_q <= bank_sel;
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_err_o = err_q;
	assign wb_dat_o = bank_dout[bank_q];

	ack_follows_strobe: assert property (
		@(posedge wb_clk_i) disable iff (reset_i)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i)
	);

endmodule

// ==== source/sram_32x512.sv ====
`timescale 1ns/1ps
`include "experiar_config.svh"

module sram_32x512 (
	input  logic                                 wb_clk_i,
	input  logic                                 cs_i,
	input  logic                                 we_i,
	input  experiar_soc_pkg::wb_sel_t            wmask_i,
	input  logic [`SRAM_ADDRESS_SIZE-1:0]        addr_i,
	input  experiar_soc_pkg::wb_data_t           din_i,
	output experiar_soc_pkg::wb_data_t           dout_o
);

	localparam int DEPTH = 1 << `SRAM_ADDRESS_SIZE;

	experiar_soc_pkg::wb_data_t mem [DEPTH];
	experiar_soc_pkg::wb_data_t dout_q;

	// Byte masked write
	always_ff @(posedge wb_clk_i) begin
		if (cs_i && we_i) begin
			for (int b = 0; b < `WB_SEL_W; b++) begin
				if (wmask_i[b]) begin
					mem[addr_i][b*8 +: 8] <= din_i[b*8 +: 8];
				end
			end
		end
	end

	// Read data shows up the cycle after the enable
	always_ff @(posedge wb_clk_i) begin
		if (cs_i && !we_i) begin
			dout_q <= mem[addr_i];
		end
	end

	assign dout_o = dout_q;

endmodule

// ==== source/wishbone_interconnect.sv ====
`timescale 1ns/1ps
`include "experiar_config.svh"

module wishbone_interconnect (
	input  logic                             wb_clk_i,
	input  logic                             reset_i,

	// Host port
	input  logic                             wb_cyc_i,
	input  logic                             wb_stb_i,
	input  logic                             wb_we_i,
	input  experiar_soc_pkg::wb_sel_t        wb_sel_i,
	input  logic [`WB_ADR_W-1:0]             wb_adr_i,
	input  experiar_soc_pkg::wb_data_t       wb_dat_i,
	output logic                             wb_ack_o,
	output logic                             wb_err_o,
	output logic                             wb_stall_o,
	output experiar_soc_pkg::wb_data_t       wb_dat_o,

	// Core 0 memory on slave 0
	input  logic                             s0_ack_i,
	input  logic                             s0_err_i,
	input  experiar_soc_pkg::wb_data_t       s0_dat_i,
	output logic                             s0_cyc_o,
	output logic                             s0_stb_o,
	output logic                             s0_we_o,
	output experiar_soc_pkg::wb_sel_t        s0_sel_o,
	output experiar_soc_pkg::slave_adr_t     s0_adr_o,
	output experiar_soc_pkg::wb_data_t       s0_dat_o,

	// Core 1 memory on slave 1
	input  logic                             s1_ack_i,
	input  logic                             s1_err_i,
	input  experiar_soc_pkg::wb_data_t       s1_dat_i,
	output logic                             s1_cyc_o,
	output logic                             s1_stb_o,
	output logic                             s1_we_o,
	output experiar_soc_pkg::wb_sel_t        s1_sel_o,
	output experiar_soc_pkg::slave_adr_t     s1_adr_o,
	output experiar_soc_pkg::wb_data_t       s1_dat_o,

	// Video memory on slave 2
	input  logic                             s2_ack_i,
	input  logic                             s2_err_i,
	input  experiar_soc_pkg::wb_data_t       s2_dat_i,
	output logic                             s2_cyc_o,
	output logic                             s2_stb_o,
	output logic                             s2_we_o,
	output experiar_soc_pkg::wb_sel_t        s2_sel_o,
	output experiar_soc_pkg::slave_adr_t     s2_adr_o,
	output experiar_soc_pkg::wb_data_t       s2_dat_o,

	output experiar_soc_pkg::slave_sel_e     probe_current_slave_o
);

	experiar_soc_pkg::slave_sel_e  dest;
	experiar_soc_pkg::slave_sel_e  last_dest_q;
	experiar_soc_pkg::slave_adr_t  slave_adr;
	logic                          accept;
	logic                          pending_q;

	// Region decode
	always_comb begin
		case (wb_adr_i[`SLAVE_IDX_HI:`SLAVE_IDX_LO])
			4'd0:    dest = experiar_soc_pkg::SLAVE_CORE0_MEM;
			4'd1:    dest = experiar_soc_pkg::SLAVE_CORE1_MEM;
			4'd2:    dest = experiar_soc_pkg::SLAVE_VIDEO_MEM;
			default: dest = experiar_soc_pkg::SLAVE_NONE;
		endcase
	end

	// Hold off a switch to another slave while a response is due
	assign wb_stall_o = wb_cyc_i && wb_stb_i && pending_q && (dest != last_dest_q);
	assign accept     = wb_cyc_i && wb_stb_i && !wb_stall_o;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			pending_q   <= 1'b0;
			last_dest_q <= experiar_soc_pkg::SLAVE_NONE;
		end else begin
			pending_q <= accept;
			if (accept) begin
				last_dest_q <= dest;
			end
		end
	end

	assign slave_adr = wb_adr_i[`SLAVE_ADR_W-1:0];

	// Only the selected slave sees the cycle and the strobe
	assign s0_cyc_o = wb_cyc_i && (dest == experiar_soc_pkg::SLAVE_CORE0_MEM);
	assign s1_cyc_o = wb_cyc_i && (dest == experiar_soc_pkg::SLAVE_CORE1_MEM);
	assign s2_cyc_o = wb_cyc_i && (dest == experiar_soc_pkg::SLAVE_VIDEO_MEM);
	assign s0_stb_o = accept && (dest == experiar_soc_pkg::SLAVE_CORE0_MEM);
	assign s1_stb_o = accept && (dest == experiar_soc_pkg::SLAVE_CORE1_MEM);
	assign s2_stb_o = accept && (dest == experiar_soc_pkg::SLAVE_VIDEO_MEM);

	// Request fields fan out to every slave
	assign s0_we_o  = wb_we_i;
	assign s1_we_o  = wb_we_i;
	assign s2_we_o  = wb_we_i;
	assign s0_sel_o = wb_sel_i;
	assign s1_sel_o = wb_sel_i;
	assign s2_sel_o = wb_sel_i;
	assign s0_adr_o = slave_adr;
	assign s1_adr_o = slave_adr;
	assign s2_adr_o = slave_adr;
	assign s0_dat_o = wb_dat_i;
	assign s1_dat_o = wb_dat_i;
	assign s2_dat_o = wb_dat_i;

	// Response comes from whoever took last cycle's request
	always_comb begin
		wb_ack_o = 1'b0;
		wb_err_o = 1'b0;
		wb_dat_o = '0;
		if (pending_q) begin
			case (last_dest_q)
				experiar_soc_pkg::SLAVE_CORE0_MEM: begin
					wb_ack_o = s0_ack_i;
					wb_err_o = s0_err_i;
					wb_dat_o = s0_dat_i;
				end
				experiar_soc_pkg::SLAVE_CORE1_MEM: begin
					wb_ack_o = s1_ack_i;
					wb_err_o = s1_err_i;
					wb_dat_o = s1_dat_i;
				end
				experiar_soc_pkg::SLAVE_VIDEO_MEM: begin
					wb_ack_o = s2_ack_i;
					wb_err_o = s2_err_i;
					wb_dat_o = s2_dat_i;
				end
				// Unmapped region answers err by itself
				default: wb_err_o = 1'b1;
			endcase
		end
	end

	assign probe_current_slave_o = last_dest_q;

	// At most one slave is strobed or answering in any cycle
	one_slave_strobe: assert property (
		@(posedge wb_clk_i) disable iff (reset_i)
		$onehot0({s0_stb_o || s0_ack_i || s0_err_i,
			s1_stb_o || s1_ack_i || s1_err_i,
			s2_stb_o || s2_ack_i || s2_err_i})
	);

	ack_err_exclusive: assert property (
		@(posedge wb_clk_i) disable iff (reset_i)
		!(wb_ack_o && wb_err_o)
	);

endmodule
